//--- logic/fabric_settings.svh
`ifndef FABRIC_SETTINGS_SVH
`define FABRIC_SETTINGS_SVH

// --------------------------------------------------
// Fabric ingress sizing
// --------------------------------------------------

// Input channels, one FIFO each
`define FABRIC_CHANNELS 4
// Words per channel FIFO, power of two
`define FABRIC_FIFO_DEPTH 8

`define FABRIC_DATA_W 32
`define FABRIC_ANC_W 3
`define FABRIC_ADDR_W 16
`define FABRIC_LEN_W 4

// Block length after reset
`define FABRIC_BLOCK_LEN_RST 4
// Register index of block length, 0..3 are channel bases
`define FABRIC_CFG_LEN_SEL 4

`endif

//--- logic/fabric_pkg.sv
`include "fabric_settings.svh"

package fabric_pkg;

  // --------------------------------------------------
  // Payload
  // --------------------------------------------------
  typedef logic [`FABRIC_DATA_W-1:0] data_t;
  typedef logic [`FABRIC_ANC_W-1:0] anc_t;

  // --------------------------------------------------
  // Channels and addressing
  // --------------------------------------------------
  typedef logic [$clog2(`FABRIC_CHANNELS)-1:0] chan_t;
  typedef logic [`FABRIC_CHANNELS-1:0] chan_mask_t;
  typedef logic [`FABRIC_ADDR_W-1:0] addr_t;

  // Block length, also the word count within a block
  typedef logic [`FABRIC_LEN_W-1:0] len_t;

  // Register index on the config port
  typedef logic [$clog2(`FABRIC_CFG_LEN_SEL+1)-1:0] cfg_sel_t;

  // Block mover FSM
  typedef enum logic [1:0] {
    IDLE,
    PICK,
    MOVE
  } mover_state_t;

endpackage

//--- logic/lsab_if.sv
`timescale 1ns/1ps

// Input buffer to block mover
interface lsab_if;

  // Per-channel empty flags
  fabric_pkg::chan_mask_t empty;

  // Head of the channel on sel
  fabric_pkg::data_t head_data;
  fabric_pkg::anc_t head_anc;

  fabric_pkg::chan_t sel;
  // Only while the selected channel is not empty
  logic pop;

  modport buffer (
    output empty, head_data, head_anc,
    input sel, pop
  );

  modport mover (
    input empty, head_data, head_anc,
    output sel, pop
  );

endinterface

//--- logic/cfg_if.sv
`timescale 1ns/1ps

// Register block to block mover
interface cfg_if;

  // Length after the zero fixup
  fabric_pkg::len_t block_len;

  // Next address of the channel on sel
  fabric_pkg::addr_t chan_addr;

  fabric_pkg::chan_t sel;
  // Steps the selected channel by one word
  logic advance;

  modport regs (
    output block_len, chan_addr,
    input sel, advance
  );

  modport mover (
    input block_len, chan_addr,
    output sel, advance
  );

endinterface

//--- logic/lsab_in.sv
`timescale 1ns/1ps

`include "fabric_settings.svh"

module lsab_in (
  input  logic                  CLK_n,
  input  logic                  RST,
  input  logic                  i_in_valid,
  input  fabric_pkg::chan_t     i_in_chan,
  input  fabric_pkg::data_t     i_in_data,
  input  fabric_pkg::anc_t      i_in_anc,
  output logic                  o_in_ready,
  lsab_if.buffer                lsab
);

  localparam int CH = `FABRIC_CHANNELS;
  localparam int DEPTH = `FABRIC_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  // Payload storage per channel and slot
  fabric_pkg::data_t mem_data [CH][DEPTH];
  fabric_pkg::anc_t mem_anc [CH][DEPTH];

  // Pointers wrap on their own since depth is a power of two
  logic [PTR_W-1:0] wr_ptr [CH];
  logic [PTR_W-1:0] rd_ptr [CH];
  logic [PTR_W:0] fill [CH];

  logic push;
  fabric_pkg::chan_mask_t push_vec;
  fabric_pkg::chan_mask_t pop_vec;

  // --------------------------------------------------
  // Push side
  // --------------------------------------------------
  assign o_in_ready = (fill[i_in_chan] != (PTR_W+1)'(DEPTH));
  assign push = i_in_valid && o_in_ready;

  always_comb
  begin
    push_vec = '0;
    pop_vec = '0;
    push_vec[i_in_chan] = push;
    pop_vec[lsab.sel] = lsab.pop;
  end

  always_ff @(posedge CLK_n)
  begin
    if (push)
    begin
      mem_data[i_in_chan][wr_ptr[i_in_chan]] <= i_in_data;
      mem_anc[i_in_chan][wr_ptr[i_in_chan]] <= i_in_anc;
    end
  end

  // --------------------------------------------------
  // Pointers and fill counts
  // --------------------------------------------------
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      for (int c = 0; c < CH; c++)
      begin
        wr_ptr[c] <= '0;
        rd_ptr[c] <= '0;
        fill[c] <= '0;
      end
    end
    else
    begin
      for (int c = 0; c < CH; c++)
      begin
        if (push_vec[c])
          wr_ptr[c] <= wr_ptr[c] + 1'b1;
        if (pop_vec[c])
          rd_ptr[c] <= rd_ptr[c] + 1'b1;
        // Push and pop together leave the fill unchanged
        case ({push_vec[c], pop_vec[c]})
          2'b10: fill[c] <= fill[c] + 1'b1;
          2'b01: fill[c] <= fill[c] - 1'b1;
          default: fill[c] <= fill[c];
        endcase
      end
    end
  end

  // --------------------------------------------------
  // Status and head word toward the mover
  // --------------------------------------------------
  always_comb
  begin
    for (int c = 0; c < CH; c++)
      lsab.empty[c] = (fill[c] == '0);
  end

  assign lsab.head_data = mem_data[lsab.sel][rd_ptr[lsab.sel]];
  assign lsab.head_anc = mem_anc[lsab.sel][rd_ptr[lsab.sel]];

endmodule

//--- logic/fabric_regs.sv
`timescale 1ns/1ps

`include "fabric_settings.svh"

module fabric_regs (
  input  logic                  CLK_n,
  input  logic                  RST,
  input  logic                  i_cfg_valid,
  input  fabric_pkg::cfg_sel_t  i_cfg_sel,
  input  fabric_pkg::addr_t     i_cfg_data,
  cfg_if.regs                   cfg
);

  localparam int CH = `FABRIC_CHANNELS;

  // Next address is kept as base plus a running offset
  fabric_pkg::addr_t base_q [CH];
  fabric_pkg::addr_t offs_q [CH];
  fabric_pkg::len_t len_q;

  logic base_wr;
  logic len_wr;
  fabric_pkg::chan_t wr_chan;

  // --------------------------------------------------
  // Write decode
  // --------------------------------------------------
  assign base_wr = i_cfg_valid && (i_cfg_sel < fabric_pkg::cfg_sel_t'(CH));
  assign len_wr = i_cfg_valid &&
                  (i_cfg_sel == fabric_pkg::cfg_sel_t'(`FABRIC_CFG_LEN_SEL));
  assign wr_chan = fabric_pkg::chan_t'(i_cfg_sel);

  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      for (int c = 0; c < CH; c++)
      begin
        base_q[c] <= '0;
        offs_q[c] <= '0;
      end
      len_q <= fabric_pkg::len_t'(`FABRIC_BLOCK_LEN_RST);
    end
    else
    begin
      for (int c = 0; c < CH; c++)
      begin
        // Base write wins over a same-cycle advance
        if (base_wr && (wr_chan == fabric_pkg::chan_t'(c)))
        begin
          base_q[c] <= i_cfg_data;
          offs_q[c] <= '0;
        end
        else if (cfg.advance && (cfg.sel == fabric_pkg::chan_t'(c)))
          offs_q[c] <= offs_q[c] + 1'b1;
      end
      if (len_wr)
        len_q <= fabric_pkg::len_t'(i_cfg_data);
    end
  end

  // --------------------------------------------------
  // Read side
  // --------------------------------------------------
  assign cfg.chan_addr = base_q[cfg.sel] + offs_q[cfg.sel];

  // Zero length behaves as one
  assign cfg.block_len = (len_q == '0) ? fabric_pkg::len_t'(1) : len_q;

endmodule

//--- logic/block_mover.sv
`timescale 1ns/1ps

`include "fabric_settings.svh"

module block_mover (
  input  logic                  CLK_n,
  input  logic                  RST,
  lsab_if.mover                 lsab,
  cfg_if.mover                  cfg,
  output logic                  o_out_valid,
  output logic                  o_out_last,
  input  logic                  i_out_ready,
  output fabric_pkg::data_t     o_out_data,
  output fabric_pkg::anc_t      o_out_anc,
  output fabric_pkg::chan_t     o_out_chan,
  output fabric_pkg::addr_t     o_out_addr
);

  localparam int CH = `FABRIC_CHANNELS;

  fabric_pkg::mover_state_t state_q;
  // Channel where the next search starts, one past the last served
  fabric_pkg::chan_t rr_ptr_q;
  fabric_pkg::chan_t active_q;
  fabric_pkg::len_t count_q;

  fabric_pkg::chan_t pick;
  fabric_pkg::len_t last_idx;
  logic fire;
  logic last;

  // --------------------------------------------------
  // Round-robin search
  // --------------------------------------------------
  always_comb
  begin : rr_search
    fabric_pkg::chan_t cand;
    logic found;
    pick = rr_ptr_q;
    found = 1'b0;
    for (int k = 0; k < CH; k++)
    begin
      cand = fabric_pkg::chan_t'(int'(rr_ptr_q) + k);
      if (!found && !lsab.empty[cand])
      begin
        pick = cand;
        found = 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Output stream
  // --------------------------------------------------
  assign o_out_valid = (state_q == fabric_pkg::MOVE) && !lsab.empty[active_q];
  assign fire = o_out_valid && i_out_ready;

  // Last by count only
  assign last_idx = cfg.block_len - 1'b1;
  assign last = (count_q == last_idx);
  assign o_out_last = o_out_valid && last;

  assign o_out_data = lsab.head_data;
  assign o_out_anc = lsab.head_anc;
  assign o_out_chan = active_q;
  assign o_out_addr = cfg.chan_addr;

  assign lsab.sel = active_q;
  assign lsab.pop = fire;
  assign cfg.sel = active_q;
  assign cfg.advance = fire;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      state_q <= fabric_pkg::IDLE;
      rr_ptr_q <= '0;
      active_q <= '0;
      count_q <= '0;
    end
    else
    begin
      case (state_q)
        fabric_pkg::IDLE:
        begin
          if (|(~lsab.empty))
            state_q <= fabric_pkg::PICK;
        end
        fabric_pkg::PICK:
        begin
          active_q <= pick;
          rr_ptr_q <= pick + 1'b1;
          count_q <= '0;
          state_q <= fabric_pkg::MOVE;
        end
        fabric_pkg::MOVE:
        begin
          if (fire)
          begin
            count_q <= count_q + 1'b1;
            if (last)
              state_q <= fabric_pkg::IDLE;
          end
          else if (lsab.empty[active_q])
            state_q <= fabric_pkg::IDLE;  // channel ran dry, block cut short
        end
        default: state_q <= fabric_pkg::IDLE;
      endcase
    end
  end

endmodule

//--- logic/fabric_ingress.sv
`timescale 1ns/1ps

module fabric_ingress (
  input  logic                  CLK_n,
  input  logic                  RST,
  // Input push
  input  logic                  i_in_valid,
  input  fabric_pkg::chan_t     i_in_chan,
  input  fabric_pkg::data_t     i_in_data,
  input  fabric_pkg::anc_t      i_in_anc,
  output logic                  o_in_ready,
  // Configuration
  input  logic                  i_cfg_valid,
  input  fabric_pkg::cfg_sel_t  i_cfg_sel,
  input  fabric_pkg::addr_t     i_cfg_data,
  // Output stream
  output logic                  o_out_valid,
  input  logic                  i_out_ready,
  output fabric_pkg::data_t     o_out_data,
  output fabric_pkg::anc_t      o_out_anc,
  output fabric_pkg::chan_t     o_out_chan,
  output fabric_pkg::addr_t     o_out_addr,
  output logic                  o_out_last
);

  lsab_if u_lsab ();
  cfg_if u_cfg ();

  // --------------------------------------------------
  lsab_in u_lsab_in (
    .CLK_n      (CLK_n),
    .RST        (RST),
    .i_in_valid (i_in_valid),
    .i_in_chan  (i_in_chan),
    .i_in_data  (i_in_data),
    .i_in_anc   (i_in_anc),
    .o_in_ready (o_in_ready),
    .lsab       (u_lsab.buffer)
  );

  fabric_regs u_regs (
    .CLK_n       (CLK_n),
    .RST         (RST),
    .i_cfg_valid (i_cfg_valid),
    .i_cfg_sel   (i_cfg_sel),
    .i_cfg_data  (i_cfg_data),
    .cfg         (u_cfg.regs)
  );

  block_mover u_mover (
    .CLK_n       (CLK_n),
    .RST         (RST),
    .lsab        (u_lsab.mover),
    .cfg         (u_cfg.mover),
    .o_out_valid (o_out_valid),
    .o_out_last  (o_out_last),
    .i_out_ready (i_out_ready),
    .o_out_data  (o_out_data),
    .o_out_anc   (o_out_anc),
    .o_out_chan  (o_out_chan),
    .o_out_addr  (o_out_addr)
  );

endmodule

//--- tests/tb_fabric_ingress.sv
`timescale 1ns/1ps

`include "fabric_settings.svh"

module tb_fabric_ingress;

  localparam int MAX_CYCLES = 2000;

  logic CLK_n;
  logic RST;
  logic i_in_valid;
  fabric_pkg::chan_t i_in_chan;
  fabric_pkg::data_t i_in_data;
  fabric_pkg::anc_t i_in_anc;
  logic o_in_ready;
  logic i_cfg_valid;
  fabric_pkg::cfg_sel_t i_cfg_sel;
  fabric_pkg::addr_t i_cfg_data;
  logic o_out_valid;
  logic i_out_ready;
  fabric_pkg::data_t o_out_data;
  fabric_pkg::anc_t o_out_anc;
  fabric_pkg::chan_t o_out_chan;
  fabric_pkg::addr_t o_out_addr;
  logic o_out_last;

  integer seed = 32'hc54b_5795;

  // Reference queues and next addresses per channel
  fabric_pkg::data_t ref_data [`FABRIC_CHANNELS][$];
  fabric_pkg::anc_t ref_anc [`FABRIC_CHANNELS][$];
  fabric_pkg::addr_t ref_addr [`FABRIC_CHANNELS];
  int ref_len;
  fabric_pkg::chan_t exp_chan_q [$];
  fabric_pkg::chan_t blk_chan = '0;
  int blk_count = 0;

  logic stalled = 1'b0;
  logic [53:0] held;
  string test_name = "reset";
  int checks = 0;
  int errors = 0;
  int test_err_base = 0;
  int tests_run = 0;
  int cycles = 0;

  fabric_ingress DUT (.*);

  initial
  begin
    CLK_n = 1'b0;
    forever #50 CLK_n = ~CLK_n;
  end

  always @(posedge CLK_n)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles in test %s", cycles, test_name);
      $display("Errors found");
      $finish;
    end
  end

  // --------------------------------------------------
  // Checks and reference model
  // --------------------------------------------------
  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    assert (exp == act)
    else
    begin
      $display("Fail %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond)
    else
    begin
      $display("Error in %s: %s", test_name, msg);
      errors++;
    end
  endtask

  // Next word of a channel as {addr, anc, data}
  function automatic logic [50:0] predict_word(input fabric_pkg::chan_t ch);
    fabric_pkg::data_t d;
    fabric_pkg::anc_t a;
    fabric_pkg::addr_t ad;
    d = ref_data[ch].pop_front();
    a = ref_anc[ch].pop_front();
    ad = ref_addr[ch];
    ref_addr[ch] = ref_addr[ch] + 16'd1;
    return {ad, a, d};
  endfunction

  function automatic int pending_words();
    int n;
    n = 0;
    for (int c = 0; c < `FABRIC_CHANNELS; c++)
      n += ref_data[c].size();
    return n;
  endfunction

  // Handshakes are sampled mid-cycle and complete on the next rising edge
  always @(negedge CLK_n)
  begin : compare
    logic [50:0] exp_word;
    if (RST)
    begin
      if (stalled)
      begin
        check_true(o_out_valid, "valid dropped while the stream was stalled");
        check_value("held fields", held,
                    {o_out_data, o_out_anc, o_out_chan, o_out_addr, o_out_last});
      end
      stalled = o_out_valid && !i_out_ready;
      held = {o_out_data, o_out_anc, o_out_chan, o_out_addr, o_out_last};
      if (o_out_valid && i_out_ready)
      begin
        if (blk_count == 0)
        begin
          if (exp_chan_q.size() == 0)
            check_true(1'b0, "a block started where none was expected");
          else
            blk_chan = exp_chan_q.pop_front();
        end
        check_value("chan", blk_chan, o_out_chan);
        check_value("last", blk_count == ref_len - 1, o_out_last);
        if (ref_data[blk_chan].size() == 0)
          check_true(1'b0, "word came out of a channel with nothing pushed");
        else
        begin
          exp_word = predict_word(blk_chan);
          check_value("addr", exp_word[50:35], o_out_addr);
          check_value("anc", exp_word[34:32], o_out_anc);
          check_value("data", exp_word[31:0], o_out_data);
        end
        blk_count = (blk_count + 1 == ref_len) ? 0 : blk_count + 1;
      end
    end
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  task automatic next_cycle();
    @(posedge CLK_n);
    #1;
  endtask

  task automatic write_cfg(input fabric_pkg::cfg_sel_t sel, input fabric_pkg::addr_t val);
    i_cfg_valid = 1'b1;
    i_cfg_sel = sel;
    i_cfg_data = val;
    next_cycle();
    i_cfg_valid = 1'b0;
    if (sel == fabric_pkg::cfg_sel_t'(`FABRIC_CFG_LEN_SEL))
      ref_len = (fabric_pkg::len_t'(val) == '0) ? 1 : int'(fabric_pkg::len_t'(val));
    else
      ref_addr[sel[1:0]] = val;
  endtask

  task automatic push_word(input fabric_pkg::chan_t ch, output logic accepted);
    logic [31:0] rnd;
    fabric_pkg::data_t d;
    d = $random(seed);
    rnd = $random(seed);
    i_in_valid = 1'b1;
    i_in_chan = ch;
    i_in_data = d;
    i_in_anc = rnd[2:0];
    @(negedge CLK_n);
    accepted = o_in_ready;
    if (accepted)
    begin
      ref_data[ch].push_back(d);
      ref_anc[ch].push_back(rnd[2:0]);
    end
    next_cycle();
    i_in_valid = 1'b0;
  endtask

  task automatic push_block(input fabric_pkg::chan_t ch, input int n);
    logic acc;
    for (int i = 0; i < n; i++)
    begin
      push_word(ch, acc);
      check_true(acc, "push refused while the FIFO had room");
    end
  endtask

  task automatic wait_drained(input logic random_ready);
    logic [31:0] rnd;
    while (pending_words() != 0)
    begin
      if (random_ready)
      begin
        rnd = $random(seed);
        i_out_ready = (rnd[1:0] != 2'b00);
      end
      else
        i_out_ready = 1'b1;
      next_cycle();
    end
    i_out_ready = 1'b0;
    repeat (2) next_cycle();
    @(negedge CLK_n);
    check_true(!o_out_valid, "extra word offered after the last expected one");
    check_true(exp_chan_q.size() == 0, "fewer blocks came out than expected");
    check_true(blk_count == 0, "last block ended without its last flag");
    next_cycle();
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err_base = errors;
  endtask

  task automatic end_test();
    tests_run++;
    $display("Test %s: %s, %0d failed checks", test_name,
             (errors == test_err_base) ? "passed" : "failed", errors - test_err_base);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial
  begin : main_seq
    logic acc;
    int n_acc;
    RST = 1'b0;
    i_in_valid = 1'b0;
    i_in_chan = '0;
    i_in_data = '0;
    i_in_anc = '0;
    i_cfg_valid = 1'b0;
    i_cfg_sel = '0;
    i_cfg_data = '0;
    i_out_ready = 1'b0;
    ref_len = `FABRIC_BLOCK_LEN_RST;
    for (int c = 0; c < `FABRIC_CHANNELS; c++)
      ref_addr[c] = '0;
    repeat (8) @(posedge CLK_n);
    #1;
    RST = 1'b1;

    start_test("reset");
    @(negedge CLK_n);
    check_value("o_out_valid", 0, o_out_valid);
    check_value("o_out_last", 0, o_out_last);
    check_value("o_in_ready", 1, o_in_ready);
    next_cycle();
    end_test();

    start_test("order_addr");
    exp_chan_q.push_back(2'd2);
    exp_chan_q.push_back(2'd2);
    write_cfg(3'd2, 16'd100);
    push_block(2'd2, 8);
    wait_drained(1'b0);
    end_test();

    start_test("block_split");
    exp_chan_q.push_back(2'd0);
    exp_chan_q.push_back(2'd0);
    write_cfg(fabric_pkg::cfg_sel_t'(`FABRIC_CFG_LEN_SEL), 16'd3);
    push_block(2'd0, 6);
    wait_drained(1'b0);
    end_test();

    start_test("round_robin");
    write_cfg(3'd1, 16'd200);
    write_cfg(3'd3, 16'd300);
    write_cfg(fabric_pkg::cfg_sel_t'(`FABRIC_CFG_LEN_SEL), 16'd4);
    exp_chan_q.push_back(2'd0);
    exp_chan_q.push_back(2'd1);
    exp_chan_q.push_back(2'd3);
    push_block(2'd0, 4);
    push_block(2'd1, 4);
    push_block(2'd3, 4);
    wait_drained(1'b0);
    end_test();

    // Channel 1 served first, so the next search starts at channel 2
    start_test("back_pressure");
    exp_chan_q.push_back(2'd1);
    exp_chan_q.push_back(2'd3);
    exp_chan_q.push_back(2'd0);
    push_block(2'd1, 4);
    push_block(2'd3, 4);
    push_block(2'd0, 4);
    wait_drained(1'b1);
    end_test();

    // Push one word more than the FIFO holds while the stream is held off
    start_test("full_fifo");
    exp_chan_q.push_back(2'd1);
    exp_chan_q.push_back(2'd1);
    n_acc = 0;
    acc = 1'b0;
    for (int i = 0; i <= `FABRIC_FIFO_DEPTH; i++)
    begin
      push_word(2'd1, acc);
      if (acc)
        n_acc++;
    end
    check_value("accepted words", `FABRIC_FIFO_DEPTH, n_acc);
    check_value("ninth word accepted", 0, acc);
    i_in_chan = 2'd2;
    @(negedge CLK_n);
    check_value("o_in_ready of other channel", 1, o_in_ready);
    next_cycle();
    wait_drained(1'b0);
    end_test();

    $display("Summary: %0d tests, %0d checks, %0d failed", tests_run, checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

//--- fabric_ingress.f
+incdir+logic
logic/fabric_pkg.sv
logic/lsab_if.sv
logic/cfg_if.sv
logic/lsab_in.sv
logic/fabric_regs.sv
logic/block_mover.sv
logic/fabric_ingress.sv
tests/tb_fabric_ingress.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fabric ingress testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fabric_ingress -f fabric_ingress.f \
  -Mdir obj_dir -o sim_fabric_ingress

./obj_dir/sim_fabric_ingress > sim.log
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"
